// File: aggregator_settings.svh
`ifndef AGGREGATOR_SETTINGS_SVH
`define AGGREGATOR_SETTINGS_SVH

// Number of peer source ports
`define NUM_SOURCES 4

// Entries per port FIFO, also the credits each sender starts with
`define SOURCE_FIFO_DEPTH 4

// Width of the per-batch bot count
`define PCOEFF_COUNT_BITWIDTH 10

// Results FIFO holds 2^5 entries
`define RESULT_FIFO_DEPTH_LOG2 5

// Free entries left when almostFull rises
// Covers the back-pressure register delay plus the pipeline depth
`define RESULT_ALMOST_FULL_MARGIN 8

`endif

// File: botTypesPkg.sv
`include "aggregator_settings.svh"

package botTypesPkg;

    // One bot or top word
    typedef logic [127:0] bot_t;

    // Index of a peer source
    typedef logic [$clog2(`NUM_SOURCES)-1:0] sourceIdx_t;

    // Masked popcount of one bot, 0 to 128
    typedef logic [7:0] coeffTerm_t;

endpackage

// File: resultTypesPkg.sv
`include "aggregator_settings.svh"

package resultTypesPkg;

    // Sum of coefficient terms over one batch
    typedef logic [`PCOEFF_COUNT_BITWIDTH+35-1:0] pcoeffSum_t;

    // Number of bots in one batch
    typedef logic [`PCOEFF_COUNT_BITWIDTH-1:0] pcoeffCount_t;

endpackage

// File: botSourcePort.sv
`include "aggregator_settings.svh"

module botSourcePort (
    input  logic              clk,
    input  logic              rst,

    // Sender side, credit based
    input  logic              botValid,
    input  botTypesPkg::bot_t bot,
    input  logic              lastBotOfBatch,
    output logic              creditReturn,

    // Arbiter side
    input  logic              pop,
    output logic              portNotEmpty,
    output botTypesPkg::bot_t portBot,
    output logic              portLast
);
    import botTypesPkg::*;

    localparam int fifoDepth = `SOURCE_FIFO_DEPTH;
    localparam int ptrWidth = $clog2(fifoDepth);

    bot_t botMem [fifoDepth];
    logic lastMem [fifoDepth];

    logic [ptrWidth-1:0] writePtr;
    logic [ptrWidth-1:0] readPtr;
    logic [ptrWidth:0]   fillLevel;

    // Circular pointer step, depth need not be a power of two
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        logic [ptrWidth-1:0] result;
        if (ptr == ptrWidth'(fifoDepth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    // Entry storage
    always_ff @(posedge clk) begin
        if (botValid) begin
            botMem[writePtr] <= bot;
            lastMem[writePtr] <= lastBotOfBatch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            fillLevel <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (botValid) begin
                writePtr <= nextPtr(writePtr);
            end
            if (pop) begin
                readPtr <= nextPtr(readPtr);
            end
            case ({botValid, pop})
                2'b10: fillLevel <= fillLevel + 1'b1;
                2'b01: fillLevel <= fillLevel - 1'b1;
                default: fillLevel <= fillLevel;
            endcase
            // One credit back per released entry
            creditReturn <= pop;
        end
    end

    // Head is always visible to the arbiter
    assign portNotEmpty = (fillLevel != '0);
    assign portBot = botMem[readPtr];
    assign portLast = lastMem[readPtr];

endmodule

// File: botArbiter.sv
`include "aggregator_settings.svh"

module botArbiter (
    input  logic                    clk,
    input  logic                    rst,

    // Port side
    input  logic [`NUM_SOURCES-1:0] portNotEmpty,
    input  botTypesPkg::bot_t       portBot [`NUM_SOURCES],
    input  logic [`NUM_SOURCES-1:0] portLast,
    input  logic                    resultsBlocked,
    output logic [`NUM_SOURCES-1:0] pop,

    // Pipeline side
    output logic                    coreBotValid,
    output botTypesPkg::bot_t       coreBot,
    output logic                    coreLast,
    output botTypesPkg::sourceIdx_t coreSource
);
    import botTypesPkg::*;

    sourceIdx_t grantIdx;
    logic       locked;

    sourceIdx_t nextIdx;
    sourceIdx_t candIdx;
    logic       nextFound;
    logic       grantedPop;

    // Round-robin search, starting after the last served port
    always_comb begin
        nextFound = 1'b0;
        nextIdx = grantIdx;
        candIdx = grantIdx;
        for (int i = 1; i <= `NUM_SOURCES; i++) begin
            candIdx = sourceIdx_t'((int'(grantIdx) + i) % `NUM_SOURCES);
            if (!nextFound && portNotEmpty[candIdx]) begin
                nextFound = 1'b1;
                nextIdx = candIdx;
            end
        end
    end

    // Pop the granted port whenever it has a bot and results can drain
    assign grantedPop = locked && !resultsBlocked && portNotEmpty[grantIdx];

    always_comb begin
        pop = '0;
        pop[grantIdx] = grantedPop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grantIdx <= sourceIdx_t'(`NUM_SOURCES - 1);
            locked <= 1'b0;
        end else if (!locked) begin
            if (nextFound) begin
                grantIdx <= nextIdx;
                locked <= 1'b1;
            end
        end else if (grantedPop && portLast[grantIdx]) begin
            // Batch complete, free the lock
            locked <= 1'b0;
        end
    end

    // Bot goes to the pipeline in its pop cycle
    assign coreBotValid = grantedPop;
    assign coreBot = portBot[grantIdx];
    assign coreLast = portLast[grantIdx];
    assign coreSource = grantIdx;

endmodule

// File: aggregatingPipeline.sv
module aggregatingPipeline (
    input  logic                        clk,
    input  logic                        rst,
    input  botTypesPkg::bot_t           sharedTop,

    // Bot input from the arbiter
    input  logic                        coreBotValid,
    input  botTypesPkg::bot_t           coreBot,
    input  logic                        coreLast,
    input  botTypesPkg::sourceIdx_t     coreSource,

    // One result per batch
    output logic                        resultValid,
    output botTypesPkg::sourceIdx_t     resultSource,
    output resultTypesPkg::pcoeffSum_t  pcoeffSum,
    output resultTypesPkg::pcoeffCount_t pcoeffCount
);
    import botTypesPkg::*;
    import resultTypesPkg::*;

    // Stage 1 registers
    logic       s1Valid;
    logic       s1Last;
    sourceIdx_t s1Source;
    coeffTerm_t s1Term;

    // Running batch state
    pcoeffSum_t   runningSum;
    pcoeffCount_t runningCount;

    pcoeffSum_t   batchSum;
    pcoeffCount_t batchCount;

    // Stage 1, masked popcount
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= coreBotValid;
        end
    end

    always_ff @(posedge clk) begin
        s1Last <= coreLast;
        s1Source <= coreSource;
        s1Term <= coeffTerm_t'($countones(coreBot & sharedTop));
    end

    // Totals including the bot now in stage 2
    assign batchSum = runningSum + pcoeffSum_t'(s1Term);
    assign batchCount = runningCount + pcoeffCount_t'(1);

    // Stage 2, accumulate and close the batch on its last bot
    always_ff @(posedge clk) begin
        if (rst) begin
            runningSum <= '0;
            runningCount <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= s1Valid && s1Last;
            if (s1Valid) begin
                if (s1Last) begin
                    runningSum <= '0;
                    runningCount <= '0;
                end else begin
                    runningSum <= batchSum;
                    runningCount <= batchCount;
                end
            end
        end
    end

    // Result fields, qualified by resultValid
    always_ff @(posedge clk) begin
        if (s1Valid && s1Last) begin
            resultSource <= s1Source;
            pcoeffSum <= batchSum;
            pcoeffCount <= batchCount;
        end
    end

endmodule

// File: resultFifo.sv
`include "aggregator_settings.svh"

module resultFifo (
    input  logic                         clk,
    input  logic                         rst,

    // Write side
    input  logic                         writeEnable,
    input  botTypesPkg::sourceIdx_t      dataSource,
    input  resultTypesPkg::pcoeffSum_t   dataSum,
    input  resultTypesPkg::pcoeffCount_t dataCount,
    output logic                         almostFull,

    // Read side, show-ahead
    input  logic                         readEnable,
    output botTypesPkg::sourceIdx_t      outSource,
    output resultTypesPkg::pcoeffSum_t   outSum,
    output resultTypesPkg::pcoeffCount_t outCount,
    output logic                         empty
);
    import botTypesPkg::*;
    import resultTypesPkg::*;

    localparam int depthLog2 = `RESULT_FIFO_DEPTH_LOG2;
    localparam int fifoDepth = 1 << depthLog2;

    sourceIdx_t   sourceMem [fifoDepth];
    pcoeffSum_t   sumMem [fifoDepth];
    pcoeffCount_t countMem [fifoDepth];

    // Pointers wrap naturally at the power-of-two depth
    logic [depthLog2-1:0] writePtr;
    logic [depthLog2-1:0] readPtr;
    logic [depthLog2:0]   occupancy;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            sourceMem[writePtr] <= dataSource;
            sumMem[writePtr] <= dataSum;
            countMem[writePtr] <= dataCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            occupancy <= '0;
        end else begin
            writePtr <= writePtr + writeEnable;
            readPtr <= readPtr + readEnable;
            occupancy <= occupancy + writeEnable - readEnable;
        end
    end

    // Fewer than the margin of entries free
    assign almostFull = occupancy > (depthLog2 + 1)'(fifoDepth - `RESULT_ALMOST_FULL_MARGIN);
    assign empty = (occupancy == '0);

    assign outSource = sourceMem[readPtr];
    assign outSum = sumMem[readPtr];
    assign outCount = countMem[readPtr];

endmodule

// File: aggregatingPipelineTop.sv
`include "aggregator_settings.svh"

module aggregatingPipelineTop (
    input  logic                         clk,
    input  logic                         rst,
    input  botTypesPkg::bot_t            sharedTop,

    // Peer sources
    input  logic [`NUM_SOURCES-1:0]      botValid,
    input  botTypesPkg::bot_t            bot [`NUM_SOURCES],
    input  logic [`NUM_SOURCES-1:0]      lastBotOfBatch,
    output logic [`NUM_SOURCES-1:0]      creditReturn,

    // Results
    input  logic                         grabResults,
    output logic                         resultsAvailable,
    output botTypesPkg::sourceIdx_t      resultSource,
    output resultTypesPkg::pcoeffSum_t   pcoeffSum,
    output resultTypesPkg::pcoeffCount_t pcoeffCount
);
    import botTypesPkg::*;
    import resultTypesPkg::*;

    logic [`NUM_SOURCES-1:0] portNotEmpty;
    bot_t                    portBot [`NUM_SOURCES];
    logic [`NUM_SOURCES-1:0] portLast;
    logic [`NUM_SOURCES-1:0] pop;

    logic       coreBotValid;
    bot_t       coreBot;
    logic       coreLast;
    sourceIdx_t coreSource;

    logic         resultValid;
    sourceIdx_t   pipeSource;
    pcoeffSum_t   pipeSum;
    pcoeffCount_t pipeCount;

    // Result register in front of the FIFO
    logic         resultValidD;
    sourceIdx_t   pipeSourceD;
    pcoeffSum_t   pipeSumD;
    pcoeffCount_t pipeCountD;

    logic almostFull;
    logic resultsBlocked;
    logic fifoEmpty;

    for (genvar g = 0; g < `NUM_SOURCES; g++) begin : gen_ports
        botSourcePort port (
            .clk(clk),
            .rst(rst),
            .botValid(botValid[g]),
            .bot(bot[g]),
            .lastBotOfBatch(lastBotOfBatch[g]),
            .creditReturn(creditReturn[g]),
            .pop(pop[g]),
            .portNotEmpty(portNotEmpty[g]),
            .portBot(portBot[g]),
            .portLast(portLast[g])
        );
    end

    botArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .portNotEmpty(portNotEmpty),
        .portBot(portBot),
        .portLast(portLast),
        .resultsBlocked(resultsBlocked),
        .pop(pop),
        .coreBotValid(coreBotValid),
        .coreBot(coreBot),
        .coreLast(coreLast),
        .coreSource(coreSource)
    );

    aggregatingPipeline computePipe (
        .clk(clk),
        .rst(rst),
        .sharedTop(sharedTop),
        .coreBotValid(coreBotValid),
        .coreBot(coreBot),
        .coreLast(coreLast),
        .coreSource(coreSource),
        .resultValid(resultValid),
        .resultSource(pipeSource),
        .pcoeffSum(pipeSum),
        .pcoeffCount(pipeCount)
    );

    // Back-pressure and result valid, registered once
    always_ff @(posedge clk) begin
        if (rst) begin
            resultsBlocked <= 1'b0;
            resultValidD <= 1'b0;
        end else begin
            resultsBlocked <= almostFull;
            resultValidD <= resultValid;
        end
    end

    always_ff @(posedge clk) begin
        pipeSourceD <= pipeSource;
        pipeSumD <= pipeSum;
        pipeCountD <= pipeCount;
    end

    resultFifo resultsFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(resultValidD),
        .dataSource(pipeSourceD),
        .dataSum(pipeSumD),
        .dataCount(pipeCountD),
        .almostFull(almostFull),
        .readEnable(grabResults),
        .outSource(resultSource),
        .outSum(pcoeffSum),
        .outCount(pcoeffCount),
        .empty(fifoEmpty)
    );

    assign resultsAvailable = !fifoEmpty;

endmodule

// File: aggregatingPipelineTop_tb.sv
`include "aggregator_settings.svh"

module aggregatingPipelineTop_tb;
    import botTypesPkg::*;
    import resultTypesPkg::*;

    localparam int numSources = `NUM_SOURCES;
    localparam int maxBatch = 6;

    logic                  clk;
    logic                  rst;
    bot_t                  sharedTop;
    logic [numSources-1:0] botValid;
    bot_t                  bot [numSources];
    logic [numSources-1:0] lastBotOfBatch;
    logic [numSources-1:0] creditReturn;
    logic                  grabResults;
    logic                  resultsAvailable;
    sourceIdx_t            resultSource;
    pcoeffSum_t            pcoeffSum;
    pcoeffCount_t          pcoeffCount;

    // Per source, bots still to send and results still owed
    bot_t         pendBot [numSources][$];
    logic         pendLast [numSources][$];
    pcoeffSum_t   expSum [numSources][$];
    pcoeffCount_t expCount [numSources][$];

    int   credits [numSources];
    int   sent [numSources];
    int   returned [numSources];
    int   gapPercent;
    logic grabEnable;
    int   batchesSent;
    int   resultsGrabbed;
    int   cycleCount;
    int   lastCoreCycle;
    int   availRiseCycle;
    int   valueErrors;
    int   creditErrors;
    int   checkErrors;
    int   waited;
    int   stalled;

    aggregatingPipelineTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bot_t randomBot();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // Sum of masked popcounts and bot count for one batch
    function automatic void referenceResult(input bot_t top, input bot_t bots [maxBatch],
            input int n, output pcoeffSum_t sum, output pcoeffCount_t count);
        sum = '0;
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < 128; i++) begin
                if (bots[b][i] && top[i]) begin
                    sum = sum + 1'b1;
                end
            end
        end
        count = pcoeffCount_t'(n);
    endfunction

    task automatic queueBatch(input int src, input int n);
        bot_t         bots [maxBatch];
        pcoeffSum_t   sum;
        pcoeffCount_t count;
        for (int b = 0; b < n; b++) begin
            bots[b] = randomBot();
            pendBot[src].push_back(bots[b]);
            pendLast[src].push_back(b == n - 1);
        end
        referenceResult(sharedTop, bots, n, sum, count);
        expSum[src].push_back(sum);
        expCount[src].push_back(count);
        batchesSent++;
    endtask

    function automatic bit allDrained();
        bit drained;
        drained = 1'b1;
        for (int s = 0; s < numSources; s++) begin
            if (pendBot[s].size() != 0 || expSum[s].size() != 0) begin
                drained = 1'b0;
            end
        end
        return drained;
    endfunction

    task automatic waitForDrain(input int limit);
        int count;
        count = 0;
        while (!allDrained() && count < limit) begin
            @(posedge clk);
            count++;
        end
        if (!allDrained()) begin
            $display("Timeout: traffic still outstanding after %0d cycles", limit);
            checkErrors++;
        end
    endtask

    // New top on a falling edge, returns just after the next rising edge
    task automatic setTop(input bot_t top);
        @(negedge clk);
        sharedTop = top;
        @(posedge clk);
    endtask

    task automatic compareHead();
        int           src;
        pcoeffSum_t   wantSum;
        pcoeffCount_t wantCount;
        src = int'(resultSource);
        if (expSum[src].size() == 0) begin
            $display("Result for source %0d arrived with no batch outstanding", src);
            valueErrors++;
        end else begin
            wantSum = expSum[src].pop_front();
            wantCount = expCount[src].pop_front();
            if (pcoeffSum !== wantSum) begin
                $display("ERR pcoeffSum source %0d: got %h, expected %h", src, pcoeffSum, wantSum);
                valueErrors++;
            end
            if (pcoeffCount !== wantCount) begin
                $display("ERR pcoeffCount source %0d: got %h, expected %h",
                         src, pcoeffCount, wantCount);
                valueErrors++;
            end
        end
    endtask

    // Senders, one bot per source and cycle while credits last
    initial begin
        botValid = '0;
        lastBotOfBatch = '0;
        creditErrors = 0;
        for (int s = 0; s < numSources; s++) begin
            bot[s] = '0;
            credits[s] = `SOURCE_FIFO_DEPTH;
            sent[s] = 0;
            returned[s] = 0;
        end
        forever begin
            @(negedge clk);
            for (int s = 0; s < numSources; s++) begin
                if (creditReturn[s]) begin
                    credits[s]++;
                    returned[s]++;
                    if (credits[s] > `SOURCE_FIFO_DEPTH) begin
                        $display("Source %0d returned a credit it never took", s);
                        creditErrors++;
                    end
                end
                botValid[s] = 1'b0;
                lastBotOfBatch[s] = 1'b0;
                if (!rst && credits[s] > 0 && pendBot[s].size() > 0
                        && ($urandom % 100) >= gapPercent) begin
                    bot[s] = pendBot[s].pop_front();
                    lastBotOfBatch[s] = pendLast[s].pop_front();
                    botValid[s] = 1'b1;
                    credits[s]--;
                    sent[s]++;
                end
            end
        end
    end

    // Result side, grab and compare, plus timing marks of the first batch
    initial begin
        grabResults = 1'b0;
        resultsGrabbed = 0;
        valueErrors = 0;
        cycleCount = 0;
        lastCoreCycle = -1;
        availRiseCycle = -1;
        forever begin
            @(negedge clk);
            cycleCount++;
            // Arbiter output, probed for the latency check
            if (lastCoreCycle < 0 && uut.coreBotValid && uut.coreLast) begin
                lastCoreCycle = cycleCount;
            end
            if (availRiseCycle < 0 && resultsAvailable) begin
                availRiseCycle = cycleCount;
            end
            grabResults = 1'b0;
            if (!rst && grabEnable && resultsAvailable) begin
                compareHead();
                grabResults = 1'b1;
                resultsGrabbed++;
            end
        end
    end

    initial begin
        void'($urandom(32'h19f50963));
        rst = 1'b1;
        sharedTop = '0;
        grabEnable = 1'b0;
        gapPercent = 0;
        batchesSent = 0;
        checkErrors = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Outputs stay quiet before any stimulus
        repeat (4) begin
            @(negedge clk);
            if (resultsAvailable !== 1'b0) begin
                $display("ERR resultsAvailable: got %h, expected 0", resultsAvailable);
                checkErrors++;
            end
            if (creditReturn !== '0) begin
                $display("ERR creditReturn: got %h, expected 0", creditReturn);
                checkErrors++;
            end
        end
        @(posedge clk);

        // Single batch of 3 into an empty system
        setTop(randomBot());
        grabEnable = 1'b1;
        queueBatch(0, 3);
        waitForDrain(100);
        if (availRiseCycle - lastCoreCycle != 4) begin
            $display("ERR resultsAvailable latency: got %h, expected %h",
                     availRiseCycle - lastCoreCycle, 4);
            checkErrors++;
        end

        // All sources at once, random batches with gaps
        setTop(randomBot());
        gapPercent = 30;
        for (int k = 0; k < 5; k++) begin
            for (int s = 0; s < numSources; s++) begin
                queueBatch(s, 1 + $urandom % maxBatch);
            end
        end
        waitForDrain(2000);

        // Results held back, more batches than FIFO entries
        setTop(randomBot());
        grabEnable = 1'b0;
        gapPercent = 0;
        for (int k = 0; k < 10; k++) begin
            for (int s = 0; s < numSources; s++) begin
                queueBatch(s, 1 + $urandom % maxBatch);
            end
        end
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!resultsAvailable && waited < 200);
        if (!resultsAvailable) begin
            $display("Timeout: no result became available under back-pressure");
            checkErrors++;
        end
        repeat (400) @(negedge clk);
        @(posedge clk);
        stalled = 0;
        for (int s = 0; s < numSources; s++) begin
            if (credits[s] == 0 && pendBot[s].size() > 0) begin
                stalled++;
            end
        end
        if (stalled == 0) begin
            $display("Back-pressure did not stall any sender");
            checkErrors++;
        end
        grabEnable = 1'b1;
        waitForDrain(3000);

        // Extreme tops, all zero then all one
        setTop('0);
        for (int s = 0; s < numSources; s++) begin
            queueBatch(s, 1 + $urandom % maxBatch);
        end
        waitForDrain(500);
        setTop('1);
        for (int s = 0; s < numSources; s++) begin
            queueBatch(s, 1 + $urandom % maxBatch);
        end
        waitForDrain(500);

        for (int s = 0; s < numSources; s++) begin
            if (returned[s] != sent[s] || credits[s] != `SOURCE_FIFO_DEPTH) begin
                $display("ERR credits source %0d: returned %h, sent %h, held %h",
                         s, returned[s], sent[s], credits[s]);
                checkErrors++;
            end
        end
        if (resultsGrabbed != batchesSent) begin
            $display("ERR result count: got %h, expected %h", resultsGrabbed, batchesSent);
            checkErrors++;
        end
        $display("Errors: value %0d, credit %0d, check %0d",
                 valueErrors, creditErrors, checkErrors);
        if (valueErrors + creditErrors + checkErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: aggregatingPipelineTop.f
+incdir+.
botTypesPkg.sv
resultTypesPkg.sv
botSourcePort.sv
botArbiter.sv
aggregatingPipeline.sv
resultFifo.sv
aggregatingPipelineTop.sv
aggregatingPipelineTop_tb.sv

// File: Makefile
BIN = obj_dir/VaggregatingPipelineTop_tb
SRCS = $(shell grep -v '^+' aggregatingPipelineTop.f) aggregator_settings.svh

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "Verification passed" sim.log

$(BIN): $(SRCS) aggregatingPipelineTop.f
	verilator --binary --timing -j 0 --top-module aggregatingPipelineTop_tb \
		-f aggregatingPipelineTop.f

clean:
	rm -rf obj_dir sim.log
